/* common/fma_acc_pkg.sv */
`default_nettype none

package fma_acc_pkg;

  // operation seen by the FMA core
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_FMADD = 2'd1
  } operation_e;

  // input FIR field sizes
  localparam int TE_BITS   = 6;
  localparam int MANT_SIZE = 8;

  // exact product of two FIRs
  localparam int MANT_MUL_RESULT_SIZE = 2 * MANT_SIZE;
  localparam int PROD_TE_BITS         = TE_BITS + 1;

  // output FIR: one extra exponent bit, same mantissa width
  localparam int FIR_OUT_TE_BITS = TE_BITS + 1;
  localparam int FIR_OUT_SIZE    = 1 + FIR_OUT_TE_BITS + MANT_SIZE;

  typedef logic signed [TE_BITS-1:0]              exp_t;
  typedef logic [MANT_SIZE-1:0]                   mant_t;
  typedef logic signed [PROD_TE_BITS-1:0]         prod_exp_t;
  typedef logic [MANT_MUL_RESULT_SIZE-1:0]        prod_mant_t;
  typedef logic [FIR_OUT_SIZE-1:0]                fir_out_t;

  // value = mant * 2^(total_exponent - (MANT_SIZE - 1)), one integer bit
  // a zero mantissa is the value zero
  typedef struct packed {
    logic  sign;
    exp_t  total_exponent;
    mant_t mant;
  } fir_t;

  // product format, binary point after the top two mantissa bits
  typedef struct packed {
    logic       sign;
    prod_exp_t  total_exponent;
    prod_mant_t mant;
  } prod_fir_t;

endpackage

`default_nettype wire

/* fma_acc.f */
common/fma_acc_pkg.sv
hdl/fir_multiplier.sv
hdl/fir_to_fixed.sv
hdl/fixed_to_fir.sv
hdl/fixed_accumulator.sv
hdl/core_fma_accumulator.sv
hdl/fma_acc_top.sv
verification/tb_fma_acc.sv

/* hdl/core_fma_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module core_fma_accumulator #(
  parameter int FX_M = 16,
  parameter int FX_B = 48
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  fma_acc_pkg::operation_e op_i,
  input  fma_acc_pkg::prod_fir_t  fir1_i,
  input  fma_acc_pkg::fir_t       fir2_i,
  output logic                   valid_o,
  output fma_acc_pkg::fir_out_t   fir_o,
  output logic [FX_B-1:0]        fixed_o
);

  fma_acc_pkg::operation_e op_st1;
  logic                    is_fmadd;
  logic                    start;
  logic [FX_B-1:0]         fir1_fixed;
  logic [FX_B-1:0]         fir2_fixed;
  logic [FX_B-1:0]         acc;

  // previous op, run edges come from comparing against it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      op_st1 <= fma_acc_pkg::OP_NONE;
    end else begin
      op_st1 <= op_i;
    end
  end

  assign is_fmadd = (op_i == fma_acc_pkg::OP_FMADD);
  assign start    = is_fmadd && (op_st1 != fma_acc_pkg::OP_FMADD);
  assign valid_o  = !is_fmadd && (op_st1 == fma_acc_pkg::OP_FMADD);

  fir_to_fixed #(
    .FIR_TE_SIZE   (fma_acc_pkg::PROD_TE_BITS),
    .FIR_FRAC_SIZE (fma_acc_pkg::MANT_MUL_RESULT_SIZE),
    .FX_M          (FX_M),
    .FX_B          (FX_B)
  ) fir_to_fixed_prod_i (
    .fir_i   (fir1_i),
    .fixed_o (fir1_fixed)
  );

  fir_to_fixed #(
    .FIR_TE_SIZE   (fma_acc_pkg::TE_BITS),
    .FIR_FRAC_SIZE (fma_acc_pkg::MANT_SIZE),
    .FX_M          (FX_M),
    .FX_B          (FX_B)
  ) fir_to_fixed_addend_i (
    .fir_i   (fir2_i),
    .fixed_o (fir2_fixed)
  );

  fixed_accumulator #(
    .FIXED_SIZE (FX_B)
  ) fixed_accumulator_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (start),
    .add_i        (is_fmadd),
    .init_value_i (fir2_fixed),
    .fixed_i      (fir1_fixed),
    .fixed_o      (acc)
  );

  fixed_to_fir #(
    .FX_M (FX_M),
    .FX_B (FX_B)
  ) fixed_to_fir_i (
    .fixed_i (acc),
    .fir_o   (fir_o)
  );

  // raw sum stays visible until the next run loads
  assign fixed_o = acc;

  // a run cannot close and open in the same cycle
  assert property (@(posedge clk_i) disable iff (rst_i) !(valid_o && start))
    else $error("core_fma_accumulator: valid and start together");

endmodule

`default_nettype wire

/* hdl/fir_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_multiplier (
  input  fma_acc_pkg::fir_t      a_i,
  input  fma_acc_pkg::fir_t      b_i,
  output fma_acc_pkg::prod_fir_t prod_o
);

  logic                           prod_zero;
  logic                           prod_sign;
  fma_acc_pkg::prod_exp_t         a_exp_ext;
  fma_acc_pkg::prod_exp_t         b_exp_ext;
  fma_acc_pkg::prod_exp_t         prod_exp;
  fma_acc_pkg::prod_mant_t        prod_mant;

  // either operand zero makes the whole product zero
  assign prod_zero = (a_i.mant == '0) || (b_i.mant == '0);

  assign prod_sign = a_i.sign ^ b_i.sign;

  // sign extend before the add so the sum cannot overflow
  assign a_exp_ext = {a_i.total_exponent[fma_acc_pkg::TE_BITS-1], a_i.total_exponent};
  assign b_exp_ext = {b_i.total_exponent[fma_acc_pkg::TE_BITS-1], b_i.total_exponent};
  assign prod_exp  = a_exp_ext + b_exp_ext;

  // 1.x times 1.x lands in [1, 4) at full width
  always_comb begin
    prod_mant = fma_acc_pkg::prod_mant_t'(a_i.mant) * fma_acc_pkg::prod_mant_t'(b_i.mant);
  end

  // clean zero so downstream never sees a signed zero
  always_comb begin
    if (prod_zero) begin
      prod_o.sign           = 1'b0;
      prod_o.total_exponent = '0;
      prod_o.mant           = '0;
    end else begin
      prod_o.sign           = prod_sign;
      prod_o.total_exponent = prod_exp;
      prod_o.mant           = prod_mant;
    end
  end

endmodule

`default_nettype wire

/* hdl/fir_to_fixed.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_to_fixed #(
  parameter int FIR_TE_SIZE   = fma_acc_pkg::TE_BITS,
  parameter int FIR_FRAC_SIZE = fma_acc_pkg::MANT_SIZE,
  parameter int FX_M          = 16,
  parameter int FX_B          = 48
) (
  input  logic [1+FIR_TE_SIZE+FIR_FRAC_SIZE-1:0] fir_i,
  output logic [FX_B-1:0]                        fixed_o
);

  // product mantissas carry two integer bits, plain FIRs one
  localparam int MANT_INT_BITS =
    (FIR_FRAC_SIZE == fma_acc_pkg::MANT_MUL_RESULT_SIZE) ? 2 : 1;
  // left shift that puts a zero exponent on the fixed binary point
  localparam int POINT_SHIFT = (FX_B - FX_M) - (FIR_FRAC_SIZE - MANT_INT_BITS);

  logic                          sign;
  logic signed [FIR_TE_SIZE-1:0] te;
  logic [FIR_FRAC_SIZE-1:0]      mant;
  logic [FX_B-1:0]               mant_ext;
  logic [FX_B-1:0]               magnitude;
  int                            shift_amt;

  assign {sign, te, mant} = fir_i;

  assign mant_ext  = FX_B'(mant);
  assign shift_amt = int'(te) + POINT_SHIFT;

  // bits shifted out below the LSB are dropped
  always_comb begin
    if (shift_amt >= 0) begin
      magnitude = mant_ext << shift_amt;
    end else begin
      magnitude = mant_ext >> (-shift_amt);
    end
  end

  // negate after truncation, so rounding is toward zero
  assign fixed_o = sign ? -magnitude : magnitude;

  // decoded operands arrive normalized
  always_comb begin
    assert final ((mant == '0) || (mant[FIR_FRAC_SIZE-1 -: MANT_INT_BITS] != '0))
      else $error("fir_to_fixed: mantissa %h is not normalized", mant);
  end

endmodule

`default_nettype wire

/* hdl/fixed_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_accumulator #(
  parameter int FIXED_SIZE = 48
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  start_i,
  input  logic                  add_i,
  input  logic [FIXED_SIZE-1:0] init_value_i,
  input  logic [FIXED_SIZE-1:0] fixed_i,
  output logic [FIXED_SIZE-1:0] fixed_o
);

  logic [FIXED_SIZE-1:0] acc_q;

  // first term seeds from the addend, later terms add on
  // overflow wraps, there is no saturation
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_q <= '0;
    end else if (start_i) begin
      acc_q <= init_value_i + fixed_i;
    end else if (add_i) begin
      acc_q <= acc_q + fixed_i;
    end
  end

  assign fixed_o = acc_q;

  // a run always begins inside an FMADD cycle
  assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> add_i)
    else $error("fixed_accumulator: start without add");

endmodule

`default_nettype wire

/* hdl/fixed_to_fir.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_to_fir #(
  parameter int FX_M = 16,
  parameter int FX_B = 48
) (
  input  logic [FX_B-1:0]       fixed_i,
  output fma_acc_pkg::fir_out_t fir_o
);

  localparam int POS_W = $clog2(FX_B);

  logic                                            sign;
  logic                                            is_zero;
  logic [FX_B-1:0]                                 magnitude;
  logic [FX_B-1:0]                                 normalized;
  logic [POS_W-1:0]                                lead_pos;
  int                                              exp_val;
  logic signed [fma_acc_pkg::FIR_OUT_TE_BITS-1:0] te;
  fma_acc_pkg::mant_t                              mant;

  assign sign      = fixed_i[FX_B-1];
  assign magnitude = sign ? -fixed_i : fixed_i;
  assign is_zero   = (fixed_i == '0);

  // priority search, the highest set bit wins
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < FX_B; i++) begin
      if (magnitude[i]) begin
        lead_pos = POS_W'(i);
      end
    end
  end

  // move the leading one to the top, zeros fill in below
  assign normalized = magnitude << (FX_B - 1 - int'(lead_pos));
  assign mant       = normalized[FX_B-1 -: fma_acc_pkg::MANT_SIZE];

  // exponent relative to the fixed binary point
  assign exp_val = int'(lead_pos) - (FX_B - FX_M);
  assign te      = fma_acc_pkg::FIR_OUT_TE_BITS'(exp_val);

  always_comb begin
    if (is_zero) begin
      fir_o = '0;
    end else begin
      fir_o = {sign, te, mant};
    end
  end

  // the search and the shift have to agree on the leading one
  always_comb begin
    assert final ((fir_o[fma_acc_pkg::MANT_SIZE-1:0] == '0) ||
                  fir_o[fma_acc_pkg::MANT_SIZE-1])
      else $error("fixed_to_fir: output mantissa %h lost its leading one",
                  fir_o[fma_acc_pkg::MANT_SIZE-1:0]);
  end

endmodule

`default_nettype wire

/* hdl/fma_acc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_acc_top #(
  parameter int FX_M = 16,
  parameter int FX_B = 48
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  fma_acc_pkg::operation_e op_i,
  input  fma_acc_pkg::fir_t       a_i,
  input  fma_acc_pkg::fir_t       b_i,
  input  fma_acc_pkg::fir_t       c_i,
  output logic                    valid_o,
  output fma_acc_pkg::fir_out_t   fir_o,
  output logic [FX_B-1:0]         fixed_o
);

  fma_acc_pkg::prod_fir_t prod;

  // exact a*b, no clock
  fir_multiplier fir_multiplier_i (
    .a_i    (a_i),
    .b_i    (b_i),
    .prod_o (prod)
  );

  core_fma_accumulator #(
    .FX_M (FX_M),
    .FX_B (FX_B)
  ) core_fma_accumulator_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .op_i    (op_i),
    .fir1_i  (prod),
    .fir2_i  (c_i),
    .valid_o (valid_o),
    .fir_o   (fir_o),
    .fixed_o (fixed_o)
  );

endmodule

`default_nettype wire

/* verification/tb_fma_acc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fma_acc;

  localparam int FX_M = 16;
  localparam int FX_B = 48;
  localparam int MSB = fma_acc_pkg::MANT_SIZE - 1;
  localparam int N_RANDOM_RUNS = 40;
  localparam int MAX_RUN = 8;
  // reset, directed runs and idle cycles, then the random runs with gaps
  localparam int PLANNED_CYCLES = 40 + N_RANDOM_RUNS * (MAX_RUN + 2);

  logic                    clk;
  logic                    rst;
  fma_acc_pkg::operation_e op;
  fma_acc_pkg::fir_t       a;
  fma_acc_pkg::fir_t       b;
  fma_acc_pkg::fir_t       c;
  logic                    valid;
  fma_acc_pkg::fir_out_t   fir;
  logic [FX_B-1:0]         fixed;

  // reference model state
  logic [31:0]             rng_state;
  logic [FX_B-1:0]         model_sum;
  logic [FX_B-1:0]         exp_fixed;
  fma_acc_pkg::fir_out_t   exp_fir;
  logic                    exp_valid;
  logic                    holding;
  logic                    fresh;

  fma_acc_top #(
    .FX_M (FX_M),
    .FX_B (FX_B)
  ) fma_acc_top_i (
    .clk_i   (clk),
    .rst_i   (rst),
    .op_i    (op),
    .a_i     (a),
    .b_i     (b),
    .c_i     (c),
    .valid_o (valid),
    .fir_o   (fir),
    .fixed_o (fixed)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(PLANNED_CYCLES * 20);
    $display("timeout: the run did not finish within %0d cycles", PLANNED_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "simulation hung");
  end

  task automatic value_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] expected);
    $display("ERROR %s: got %h expected %h", name, got, expected);
    $display("STATUS: FAIL");
    $fatal(1, "output check failed");
  endtask

  task automatic rule_broken(input string what);
    $display("check failed: %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "output check failed");
  endtask

  assert property (@(posedge clk) disable iff (rst) valid == exp_valid)
    else value_mismatch("valid_o", 64'($sampled(valid)), 64'($sampled(exp_valid)));

  assert property (@(posedge clk) disable iff (rst) fresh |-> fixed == '0)
    else value_mismatch("fixed_o", 64'($sampled(fixed)), 64'd0);

  // result stays put from the valid cycle until the next run loads
  assert property (@(posedge clk) disable iff (rst) (valid || holding) |-> fixed == exp_fixed)
    else value_mismatch("fixed_o", 64'($sampled(fixed)), 64'($sampled(exp_fixed)));

  assert property (@(posedge clk) disable iff (rst) valid |-> fir == exp_fir)
    else value_mismatch("fir_o", 64'($sampled(fir)), 64'($sampled(exp_fir)));

  assert property (@(posedge clk) disable iff (rst) valid |-> (fir[MSB:0] == '0 || fir[MSB]))
    else rule_broken("fir_o mantissa is nonzero but its top bit is clear");

  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = next_rand();
    return lo + r % (hi - lo + 1);
  endfunction

  function automatic fma_acc_pkg::fir_t random_fir(input int lo, input int hi, input bit zero_ok);
    fma_acc_pkg::fir_t f;
    int                r;
    r = next_rand();
    f.sign = r[8];
    f.total_exponent = fma_acc_pkg::exp_t'(rand_range(lo, hi));
    f.mant = {1'b1, r[6:0]};
    if (zero_ok && rand_range(0, 15) == 0) begin
      f.mant = '0;
    end
    return f;
  endfunction

  // mag scaled by 2^lsb_exp in fixed LSB units, truncated toward zero
  function automatic logic [FX_B-1:0] term_fixed(input logic sgn, input int lsb_exp,
                                                 input longint unsigned mag);
    logic [FX_B-1:0] v;
    v = FX_B'(mag);
    if (lsb_exp >= 0) begin
      v = v << lsb_exp;
    end else begin
      v = v >> (-lsb_exp);
    end
    return sgn ? -v : v;
  endfunction

  function automatic logic [FX_B-1:0] addend_fixed(input fma_acc_pkg::fir_t f);
    int e;
    e = $signed(f.total_exponent);
    return term_fixed(f.sign, e - MSB + (FX_B - FX_M), longint'(f.mant));
  endfunction

  function automatic logic [FX_B-1:0] product_fixed(input fma_acc_pkg::fir_t fa,
                                                    input fma_acc_pkg::fir_t fb);
    int e;
    e = $signed(fa.total_exponent) + $signed(fb.total_exponent);
    return term_fixed(fa.sign ^ fb.sign, e - 2 * MSB + (FX_B - FX_M),
                      longint'(fa.mant) * longint'(fb.mant));
  endfunction

  function automatic fma_acc_pkg::fir_out_t fir_of_fixed(input logic [FX_B-1:0] x);
    logic [FX_B-1:0]                          mag;
    logic                                     sgn;
    int                                       p;
    logic [fma_acc_pkg::FIR_OUT_TE_BITS-1:0] te;
    fma_acc_pkg::mant_t                       m;
    if (x == '0) begin
      return '0;
    end
    sgn = x[FX_B-1];
    mag = sgn ? -x : x;
    p = FX_B - 1;
    while (!mag[p]) begin
      p--;
    end
    if (p >= MSB) begin
      m = fma_acc_pkg::mant_t'(mag >> (p - MSB));
    end else begin
      m = fma_acc_pkg::mant_t'(mag << (MSB - p));
    end
    te = fma_acc_pkg::FIR_OUT_TE_BITS'(p - (FX_B - FX_M));
    return {sgn, te, m};
  endfunction

  task automatic fmadd_cycle(input fma_acc_pkg::fir_t fa, input fma_acc_pkg::fir_t fb,
                             input fma_acc_pkg::fir_t fc, input bit first);
    @(negedge clk);
    op = fma_acc_pkg::OP_FMADD;
    a = fa;
    b = fb;
    c = fc;
    exp_valid = 1'b0;
    holding = 1'b0;
    fresh = 1'b0;
    // only the first addend of a run counts
    if (first) begin
      model_sum = addend_fixed(fc) + product_fixed(fa, fb);
    end else begin
      model_sum = model_sum + product_fixed(fa, fb);
    end
  endtask

  task automatic close_run();
    @(negedge clk);
    op = fma_acc_pkg::OP_NONE;
    a = random_fir(-16, 3, 1'b1);
    c = random_fir(-30, 6, 1'b1);
    exp_fixed = model_sum;
    exp_fir = fir_of_fixed(model_sum);
    exp_valid = 1'b1;
    holding = 1'b1;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    op = fma_acc_pkg::OP_NONE;
    exp_valid = 1'b0;
  endtask

  task automatic random_run(input int len);
    for (int i = 0; i < len; i++) begin
      fmadd_cycle(random_fir(-16, 3, 1'b1), random_fir(-16, 3, 1'b1),
                  random_fir(-30, 6, 1'b1), i == 0);
    end
    close_run();
  endtask

  initial begin
    fma_acc_pkg::fir_t pa;
    fma_acc_pkg::fir_t pb;
    fma_acc_pkg::fir_t pc;
    fma_acc_pkg::fir_t one;
    op = fma_acc_pkg::OP_NONE;
    a = '0;
    b = '0;
    c = '0;
    rst = 1'b1;
    rng_state = 32'h3067;
    model_sum = '0;
    exp_fixed = '0;
    exp_fir = '0;
    exp_valid = 1'b0;
    holding = 1'b0;
    fresh = 1'b1;
    one = '{sign: 1'b0, total_exponent: '0, mant: 8'h80};
    repeat (5) @(negedge clk);
    rst = 1'b0;
    repeat (3) idle_cycle();

    fmadd_cycle(random_fir(-16, 3, 1'b0), random_fir(-16, 3, 1'b0),
                random_fir(-30, 6, 1'b0), 1'b1);
    close_run();

    // a times one against minus a
    pa = random_fir(-8, 3, 1'b0);
    pc = pa;
    pc.sign = ~pa.sign;
    fmadd_cycle(pa, one, pc, 1'b1);
    close_run();

    // two products of opposite sign, zero addend
    pa = random_fir(-16, 3, 1'b0);
    pb = random_fir(-16, 3, 1'b0);
    pc = '0;
    fmadd_cycle(pa, pb, pc, 1'b1);
    pa.sign = ~pa.sign;
    fmadd_cycle(pa, pb, random_fir(-30, 6, 1'b0), 1'b0);
    close_run();

    for (int r = 0; r < N_RANDOM_RUNS; r++) begin
      random_run(rand_range(2, MAX_RUN));
      if (rand_range(0, 3) == 0) begin
        idle_cycle();
      end
    end
    repeat (3) idle_cycle();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
